// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module cache_tb -f verilog.f -o cache_tb_sim
	./obj_dir/cache_tb_sim

clean:
	rm -rf obj_dir

// ==== hw/cache_burst_engine.sv ====
module cache_burst_engine (
    input logic clk,
    input logic rst,
    input logic refill_start,
    input logic [31:0] refill_addr,
    input logic wb_start,
    input logic [31:0] wb_addr,
    input logic [31:0] wb_data,
    output logic [cache_pkg::OFFSET_WIDTH-1:0] wb_offset,
    output logic wb_busy,
    output cache_pkg::axi_r_t refill_beat,
    output logic refill_done,
    output logic wb_done,
    output cache_pkg::axi_addr_t ar,
    input logic arready,
    output cache_pkg::axi_addr_t aw,
    input logic awready,
    input cache_pkg::axi_r_t r,
    output logic rready,
    output cache_pkg::axi_w_t w,
    input logic wready,
    input logic bvalid,
    output logic bready
);

    import cache_pkg::*;

    typedef enum logic [2:0] {
        E_IDLE,
        E_AR,
        E_R,
        E_AW,
        E_W,
        E_B
    } eng_state_t;

    eng_state_t state;
    logic [31:0] addr_q;
    logic [OFFSET_WIDTH-1:0] beat_cnt;
    logic [OFFSET_WIDTH-1:0] beat_offset;
    logic w_fire;
    addr_fields_t wb_f;

    assign wb_f = addr_fields_t'(wb_addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= E_IDLE;
            beat_cnt <= '0;
            beat_offset <= '0;
        end else begin
            case (state)
                E_IDLE: begin
                    if (refill_start) begin
                        state <= E_AR;
                    end else if (wb_start) begin
                        state <= E_AW;
                        beat_offset <= wb_f.offset;
                    end
                end
                E_AR: begin
                    if (arready) begin
                        state <= E_R;
                        beat_cnt <= '0;
                    end
                end
                E_R: begin
                    if (r.valid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (r.last) begin
                            state <= E_IDLE;
                        end
                    end
                end
                E_AW: begin
                    if (awready) begin
                        state <= E_W;
                        beat_cnt <= '0;
                    end
                end
                E_W: begin
                    if (wready) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        beat_offset <= beat_offset + 1'b1;
                        if (beat_cnt == BURST_LEN) begin
                            state <= E_B;
                        end
                    end
                end
                E_B: begin
                    if (bvalid) begin
                        state <= E_IDLE;
                    end
                end
                default: state <= E_IDLE;
            endcase
        end
    end

    // burst address, latched at the start pulse
    always_ff @(posedge clk) begin
        if (state == E_IDLE && refill_start) begin
            addr_q <= refill_addr;
        end else if (state == E_IDLE && wb_start) begin
            addr_q <= wb_addr;
        end
    end

    assign ar = '{addr: addr_q, len: BURST_LEN, size: AXI_SIZE_WORD,
                  burst: AXI_BURST_WRAP, valid: state == E_AR};
    assign aw = '{addr: addr_q, len: BURST_LEN, size: AXI_SIZE_WORD,
                  burst: AXI_BURST_WRAP, valid: state == E_AW};

    assign rready = (state == E_R);
    assign refill_beat = '{data: r.data, last: r.last, valid: r.valid && rready};
    assign refill_done = refill_beat.valid && r.last;

    // store read runs one word ahead so wb_data is ready on the next beat
    assign w_fire = (state == E_W) && wready;
    assign wb_offset = w_fire ? beat_offset + 1'b1 : beat_offset;
    assign wb_busy = (state == E_AW) || (state == E_W);

    assign w = '{data: wb_data, strb: 4'b1111, last: beat_cnt == BURST_LEN,
                 valid: state == E_W};

    assign bready = (state == E_B);
    assign wb_done = bvalid && bready;

    assert property (@(posedge clk) disable iff (rst)
        (refill_start || wb_start) |-> (state == E_IDLE && !(refill_start && wb_start)));

    // slave must close the refill on exactly the 16th beat
    assert property (@(posedge clk) disable iff (rst)
        refill_beat.valid |-> (r.last == (beat_cnt == BURST_LEN)));

endmodule

// ==== hw/cache_ctrl.sv ====
module cache_ctrl (
    input logic clk,
    input logic rst,
    input logic cpu_req,
    input cache_pkg::cpu_req_t cpu_in,
    output logic cpu_addr_ok,
    output logic cpu_data_ok,
    output logic [31:0] cpu_rdata,
    output logic [cache_pkg::INDEX_WIDTH-1:0] rd_index,
    output logic [cache_pkg::OFFSET_WIDTH-1:0] rd_offset,
    input cache_pkg::store_rd_t rd,
    output cache_pkg::store_wr_t store_wr,
    output logic refill_start,
    output logic [31:0] refill_addr,
    output logic wb_start,
    output logic [31:0] wb_addr,
    input cache_pkg::axi_r_t refill_beat,
    input logic refill_done,
    input logic wb_done
);

    import cache_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WRITE_HIT,
        S_WB_WAIT,
        S_REFILL_WAIT
    } ctrl_state_t;

    ctrl_state_t state;
    cpu_req_t req;
    addr_fields_t req_f;
    addr_fields_t cur_f;
    logic [OFFSET_WIDTH-1:0] fill_offset;
    logic hit;

    // size 2 is three bytes and size 3 a full word
    function automatic logic [3:0] byte_strb(input logic [1:0] size, input logic [1:0] bsel);
        case (size)
            2'd0: byte_strb = 4'b0001 << bsel;
            2'd1: byte_strb = 4'b0011 << bsel;
            2'd2: byte_strb = 4'b0111 << bsel;
            default: byte_strb = 4'b1111;
        endcase
    endfunction

    assign req_f = addr_fields_t'(req.addr);

    // read the store with the incoming address while idle
    assign cur_f = (state == S_IDLE) ? addr_fields_t'(cpu_in.addr) : req_f;
    assign rd_index = cur_f.index;
    assign rd_offset = cur_f.offset;

    assign hit = rd.valid && (rd.tag == req_f.tag);

    assign cpu_addr_ok = cpu_req && (state == S_IDLE);
    assign cpu_data_ok = (state == S_LOOKUP) && hit;
    assign cpu_rdata = rd.data;

    assign refill_addr = {req.addr[31:2], 2'b00};

    always_ff @(posedge clk) begin
        if (state == S_IDLE && cpu_req) begin
            req <= cpu_in;
        end
    end

    // victim line address at the requested word
    always_ff @(posedge clk) begin
        if (state == S_LOOKUP) begin
            wb_addr <= {rd.tag, req_f.index, req_f.offset, 2'b00};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            refill_start <= 1'b0;
            wb_start <= 1'b0;
            store_wr.en <= 1'b0;
            fill_offset <= '0;
        end else begin
            refill_start <= 1'b0;
            wb_start <= 1'b0;
            store_wr.en <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (cpu_req) begin
                        state <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    fill_offset <= req_f.offset;
                    if (hit) begin
                        if (req.wr) begin
                            store_wr <= '{en: 1'b1, index: req_f.index,
                                          offset: req_f.offset, tag: req_f.tag,
                                          data: req.wdata,
                                          strb: byte_strb(req.size, req_f.byte_sel),
                                          dirty: 1'b1, valid: 1'b1};
                            state <= S_WRITE_HIT;
                        end else begin
                            state <= S_IDLE;
                        end
                    end else if (rd.valid && rd.dirty) begin
                        wb_start <= 1'b1;
                        state <= S_WB_WAIT;
                    end else begin
                        refill_start <= 1'b1;
                        state <= S_REFILL_WAIT;
                    end
                end
                S_WRITE_HIT: begin
                    state <= S_IDLE;
                end
                S_WB_WAIT: begin
                    if (wb_done) begin
                        refill_start <= 1'b1;
                        state <= S_REFILL_WAIT;
                    end
                end
                S_REFILL_WAIT: begin
                    if (refill_beat.valid) begin
                        // refilled words arrive wrapped from the requested one
                        store_wr <= '{en: 1'b1, index: req_f.index, offset: fill_offset,
                                      tag: req_f.tag, data: refill_beat.data,
                                      strb: 4'b1111, dirty: 1'b0, valid: 1'b1};
                        fill_offset <= fill_offset + 1'b1;
                    end
                    if (refill_done) begin
                        state <= S_LOOKUP;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // the repeated lookup after a refill always hits
    assert property (@(posedge clk) disable iff (rst)
        refill_done |=> cpu_data_ok);

    // the engine only closes a refill that this controller started
    assert property (@(posedge clk) disable iff (rst)
        refill_done |-> (state == S_REFILL_WAIT));

endmodule

// ==== hw/cache_line_store.sv ====
module cache_line_store (
    input logic clk,
    input logic rst,
    input logic [cache_pkg::INDEX_WIDTH-1:0] rd_index,
    input logic [cache_pkg::OFFSET_WIDTH-1:0] rd_offset,
    output cache_pkg::store_rd_t rd,
    input cache_pkg::store_wr_t wr
);

    import cache_pkg::*;

    // per-line tag and flags
    logic [TAG_WIDTH-1:0] tag_mem [NUM_LINES];
    logic [NUM_LINES-1:0] valid_bits;
    logic [NUM_LINES-1:0] dirty_bits;

    // line data, one word per entry, addressed by {index, offset}
    logic [31:0] data_mem [NUM_LINES*WORDS_PER_LINE];

    logic [INDEX_WIDTH+OFFSET_WIDTH-1:0] rd_word;
    logic [INDEX_WIDTH+OFFSET_WIDTH-1:0] wr_word;

    assign rd_word = {rd_index, rd_offset};
    assign wr_word = {wr.index, wr.offset};

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (wr.en) begin
            valid_bits[wr.index] <= wr.valid;
            dirty_bits[wr.index] <= wr.dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.en) begin
            tag_mem[wr.index] <= wr.tag;
        end
    end

    // byte merge into the addressed word
    always_ff @(posedge clk) begin
        if (wr.en) begin
            for (int b = 0; b < 4; b++) begin
                if (wr.strb[b]) begin
                    data_mem[wr_word][8*b +: 8] <= wr.data[8*b +: 8];
                end
            end
        end
    end

    // registered read, old contents on a same-cycle write
    always_ff @(posedge clk) begin
        rd <= '{
            tag: tag_mem[rd_index],
            valid: valid_bits[rd_index],
            dirty: dirty_bits[rd_index],
            data: data_mem[rd_word]
        };
    end

    // a valid line write always touches at least one byte
    assert property (@(posedge clk) disable iff (rst)
        (wr.en && wr.valid) |-> (wr.strb != 4'b0000));

endmodule

// ==== hw/cache_pkg.sv ====
package cache_pkg;

    // address geometry
    localparam int TAG_WIDTH = 20;
    localparam int LINE_WIDTH = 6;
    localparam int INDEX_WIDTH = 32 - TAG_WIDTH - LINE_WIDTH;
    localparam int NUM_LINES = 64;
    localparam int OFFSET_WIDTH = 4;
    localparam int WORDS_PER_LINE = 16;

    // fixed AXI burst shape for refill and write-back
    localparam logic [3:0] BURST_LEN = 4'd15;
    localparam logic [2:0] AXI_SIZE_WORD = 3'd2;
    localparam logic [1:0] AXI_BURST_WRAP = 2'd2;

    typedef struct packed {
        logic [TAG_WIDTH-1:0] tag;
        logic [INDEX_WIDTH-1:0] index;
        logic [OFFSET_WIDTH-1:0] offset;
        logic [1:0] byte_sel;
    } addr_fields_t;

    typedef struct packed {
        logic wr;
        logic [1:0] size;
        logic [31:0] addr;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic en;
        logic [INDEX_WIDTH-1:0] index;
        logic [OFFSET_WIDTH-1:0] offset;
        logic [TAG_WIDTH-1:0] tag;
        logic [31:0] data;
        logic [3:0] strb;
        logic dirty;
        logic valid;
    } store_wr_t;

    typedef struct packed {
        logic [TAG_WIDTH-1:0] tag;
        logic valid;
        logic dirty;
        logic [31:0] data;
    } store_rd_t;

    // shared by AR and AW
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0] len;
        logic [2:0] size;
        logic [1:0] burst;
        logic valid;
    } axi_addr_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0] strb;
        logic last;
        logic valid;
    } axi_w_t;

    typedef struct packed {
        logic [31:0] data;
        logic last;
        logic valid;
    } axi_r_t;

endpackage

// ==== hw/cache_top.sv ====
module cache_top (
    input logic clk,
    input logic rst,
    input logic cpu_req,
    input cache_pkg::cpu_req_t cpu_in,
    output logic cpu_addr_ok,
    output logic cpu_data_ok,
    output logic [31:0] cpu_rdata,
    output cache_pkg::axi_addr_t ar,
    input logic arready,
    input cache_pkg::axi_r_t r,
    output logic rready,
    output cache_pkg::axi_addr_t aw,
    input logic awready,
    output cache_pkg::axi_w_t w,
    input logic wready,
    input logic bvalid,
    output logic bready
);

    import cache_pkg::*;

    store_wr_t store_wr;
    store_rd_t store_rd;
    axi_r_t refill_beat;
    logic [INDEX_WIDTH-1:0] rd_index;
    logic [OFFSET_WIDTH-1:0] ctrl_rd_offset;
    logic [OFFSET_WIDTH-1:0] wb_offset;
    logic [OFFSET_WIDTH-1:0] store_rd_offset;
    logic wb_busy;
    logic refill_start;
    logic [31:0] refill_addr;
    logic wb_start;
    logic [31:0] wb_addr;
    logic refill_done;
    logic wb_done;

    // write-back owns the word select while it streams the line
    assign store_rd_offset = wb_busy ? wb_offset : ctrl_rd_offset;

    cache_ctrl ctrl_i (
        .clk(clk), .rst(rst),
        .cpu_req(cpu_req), .cpu_in(cpu_in),
        .cpu_addr_ok(cpu_addr_ok), .cpu_data_ok(cpu_data_ok), .cpu_rdata(cpu_rdata),
        .rd_index(rd_index), .rd_offset(ctrl_rd_offset),
        .rd(store_rd), .store_wr(store_wr),
        .refill_start(refill_start), .refill_addr(refill_addr),
        .wb_start(wb_start), .wb_addr(wb_addr),
        .refill_beat(refill_beat), .refill_done(refill_done), .wb_done(wb_done)
    );

    cache_line_store store_i (
        .clk(clk), .rst(rst),
        .rd_index(rd_index), .rd_offset(store_rd_offset),
        .rd(store_rd), .wr(store_wr)
    );

    cache_burst_engine burst_i (
        .clk(clk), .rst(rst),
        .refill_start(refill_start), .refill_addr(refill_addr),
        .wb_start(wb_start), .wb_addr(wb_addr), .wb_data(store_rd.data),
        .wb_offset(wb_offset), .wb_busy(wb_busy),
        .refill_beat(refill_beat), .refill_done(refill_done), .wb_done(wb_done),
        .ar(ar), .arready(arready), .aw(aw), .awready(awready),
        .r(r), .rready(rready), .w(w), .wready(wready),
        .bvalid(bvalid), .bready(bready)
    );

endmodule

// ==== testbench/axi_mem_model.sv ====
module axi_mem_model (
    input logic clk,
    input logic rst,
    input logic [3:0] delay_bits,
    input cache_pkg::axi_addr_t ar,
    output logic arready,
    output cache_pkg::axi_r_t r,
    input logic rready,
    input cache_pkg::axi_addr_t aw,
    output logic awready,
    input cache_pkg::axi_w_t w,
    output logic wready,
    output logic bvalid,
    input logic bready
);

    timeunit 1ns;
    timeprecision 1ns;

    localparam int MEM_WORDS = 8192;

    logic [31:0] mem [MEM_WORDS];
    logic rd_busy;
    logic [8:0] rd_line;
    logic [3:0] rd_word;
    logic [3:0] rd_count;
    logic wr_busy;
    logic [8:0] wr_line;
    logic [3:0] wr_word;

    function automatic logic [31:0] init_word(input logic [31:0] addr);
        init_word = (addr * 32'h9e3779b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5bd1e995;
    endfunction

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[13'(i)] <= init_word(32'(4 * i));
        end
    end

    // delay bits gate each ready and the read data valid
    assign arready = !rd_busy && delay_bits[0];
    assign r = '{data: mem[{rd_line, rd_word}], last: rd_count == 4'd15,
                 valid: rd_busy && delay_bits[1]};
    assign awready = !wr_busy && !bvalid && delay_bits[2];
    assign wready = wr_busy && delay_bits[3];

    always @(posedge clk) begin
        if (rst) begin
            rd_busy <= 1'b0;
            wr_busy <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            if (ar.valid && arready) begin
                rd_busy <= 1'b1;
                rd_line <= ar.addr[14:6];
                rd_word <= ar.addr[5:2];
                rd_count <= 4'd0;
            end
            // word index wraps inside the 64-byte line
            if (r.valid && rready) begin
                rd_word <= rd_word + 4'd1;
                rd_count <= rd_count + 4'd1;
                rd_busy <= !r.last;
            end
            if (aw.valid && awready) begin
                wr_busy <= 1'b1;
                wr_line <= aw.addr[14:6];
                wr_word <= aw.addr[5:2];
            end
            if (w.valid && wready) begin
                for (int b = 0; b < 4; b++) begin
                    if (w.strb[b]) begin
                        mem[{wr_line, wr_word}][8*b +: 8] <= w.data[8*b +: 8];
                    end
                end
                wr_word <= wr_word + 4'd1;
                if (w.last) begin
                    wr_busy <= 1'b0;
                    bvalid <= 1'b1;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

endmodule

// ==== testbench/cache_tb.sv ====
module cache_tb;

    timeunit 1ns;
    timeprecision 1ns;

    import cache_pkg::*;

    localparam logic [31:0] SEED = 32'h03569f52;
    localparam int NUM_STEPS = 300;
    localparam int NUM_REQS = 2 * NUM_STEPS + 4;
    localparam int CYCLES_PER_REQ = 400;
    localparam int MEM_BYTES = 32768;

    logic clk = 1'b0;
    logic rst;
    logic cpu_req;
    cpu_req_t cpu_in;
    logic cpu_addr_ok;
    logic cpu_data_ok;
    logic [31:0] cpu_rdata;
    axi_addr_t ar;
    axi_addr_t aw;
    axi_r_t r;
    axi_w_t w;
    logic arready;
    logic rready;
    logic awready;
    logic wready;
    logic bvalid;
    logic bready;

    logic [31:0] rng_state;
    logic [31:0] jitter = SEED;
    logic [7:0] ref_mem [MEM_BYTES];
    // tag of the last access to each set
    logic [19:0] last_tag [NUM_LINES];
    logic [31:0] cur_addr;
    logic pending = 1'b0;
    int w_beats = 0;

    cache_top dut_i (.*);

    axi_mem_model mem_i (.delay_bits(jitter[31:28]), .*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        jitter <= lcg_next(jitter);
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        lcg_next = s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] init_word(input logic [31:0] addr);
        init_word = (addr * 32'h9e3779b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5bd1e995;
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        logic [14:0] a;
        a = {addr[14:2], 2'b00};
        ref_word = {ref_mem[a + 15'd3], ref_mem[a + 15'd2], ref_mem[a + 15'd1], ref_mem[a]};
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // byte lanes follow the address
    task automatic store_bytes(input logic [1:0] size, input logic [31:0] addr,
                               input logic [31:0] data);
        int first;
        int count;
        first = (size == 2'd3) ? 0 : int'(addr[1:0]);
        count = (size == 2'd0) ? 1 : ((size == 2'd1) ? 2 : 4);
        for (int b = first; b < first + count; b++) begin
            ref_mem[15'({addr[14:2], 2'b00} + b)] = data[8*b +: 8];
        end
    endtask

    task automatic access(input logic wr, input logic [1:0] size, input logic [31:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output int latency);
        @(posedge clk);
        cur_addr = addr;
        cpu_req <= 1'b1;
        cpu_in <= '{wr: wr, size: size, addr: addr, wdata: wdata};
        @(negedge clk);
        while (!cpu_addr_ok) begin
            @(negedge clk);
        end
        // req stays up until data_ok to probe for an early accept
        @(posedge clk);
        latency = 1;
        @(negedge clk);
        while (!cpu_data_ok) begin
            @(negedge clk);
            latency++;
        end
        rdata = cpu_rdata;
        last_tag[addr[11:6]] = addr[31:12];
        @(posedge clk);
        cpu_req <= 1'b0;
    endtask

    // bus monitor
    always @(negedge clk) begin
        if (!rst) begin
            if (pending) begin
                check("addr_ok while busy", 32'd0, {31'd0, cpu_addr_ok});
            end
            if (cpu_data_ok) begin
                pending = 1'b0;
            end
            if (cpu_addr_ok) begin
                pending = 1'b1;
            end
            if (ar.valid && arready) begin
                check("ar addr", {cur_addr[31:2], 2'b00}, ar.addr);
                check("ar burst", {23'd0, 4'd15, 3'd2, 2'd2}, {23'd0, ar.len, ar.size, ar.burst});
            end
            if (aw.valid && awready) begin
                check("aw addr", {last_tag[cur_addr[11:6]], cur_addr[11:2], 2'b00}, aw.addr);
                check("aw burst", {23'd0, 4'd15, 3'd2, 2'd2}, {23'd0, aw.len, aw.size, aw.burst});
            end
            if (w.valid && wready) begin
                w_beats = w_beats + 1;
                check("w last", {31'd0, w_beats == 16}, {31'd0, w.last});
                if (w.last) begin
                    w_beats = 0;
                end
            end
        end
    end

    initial begin
        #(NUM_REQS * CYCLES_PER_REQ * 100);
        $display("no response within time limit");
        $display("sim failed");
        $fatal(1);
    end

    initial begin
        logic [31:0] rnd;
        logic [31:0] wdata;
        logic [31:0] addr;
        logic [31:0] rdata;
        logic [31:0] word;
        logic [1:0] size;
        int latency;
        rst <= 1'b1;
        cpu_req <= 1'b0;
        cpu_in <= '0;
        rng_state = SEED;
        for (int i = 0; i < MEM_BYTES / 4; i++) begin
            word = init_word(32'(4 * i));
            for (int b = 0; b < 4; b++) begin
                ref_mem[15'(4 * i + b)] = word[8*b +: 8];
            end
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // 4 tags over 4 sets
        for (int n = 0; n < NUM_STEPS; n++) begin
            rng_state = lcg_next(rng_state);
            rnd = rng_state;
            rng_state = lcg_next(rng_state);
            wdata = rng_state;
            addr = {18'd0, rnd[31:30], rnd[29:28], 4'hb, rnd[27:24], 2'b00};
            if (rnd[21]) begin
                size = rnd[20] ? 2'd3 : {1'b0, rnd[19]};
                if (size == 2'd0) begin
                    addr[1:0] = rnd[23:22];
                end
                if (size == 2'd1) begin
                    addr[1] = rnd[23];
                end
                access(1'b1, size, addr, wdata, rdata, latency);
                store_bytes(size, addr, wdata);
                access(1'b0, 2'd3, addr, 32'd0, rdata, latency);
                check("read after write", ref_word(addr), rdata);
            end else begin
                access(1'b0, 2'd3, addr, 32'd0, rdata, latency);
                check("read", ref_word(addr), rdata);
                addr[5:2] = rnd[18:15];
                access(1'b0, 2'd3, addr, 32'd0, rdata, latency);
                check("read same line", ref_word(addr), rdata);
                check("hit latency", 32'd1, 32'(latency));
            end
        end

        // a fifth tag evicts every dirty line
        for (int i = 0; i < 4; i++) begin
            addr = {20'd4, 2'(i), 4'hb, 6'd0};
            access(1'b0, 2'd3, addr, 32'd0, rdata, latency);
            check("flush read", ref_word(addr), rdata);
        end
        for (int i = 0; i < MEM_BYTES / 4; i++) begin
            check("memory after flush", ref_word(32'(4 * i)), mem_i.mem[13'(i)]);
        end

        $display("sim passed");
        $finish;
    end

endmodule

// ==== verilog.f ====
hw/cache_pkg.sv
hw/cache_line_store.sv
hw/cache_burst_engine.sv
hw/cache_ctrl.sv
hw/cache_top.sv
testbench/axi_mem_model.sv
testbench/cache_tb.sv
